// File: run.sh
#!/bin/sh
# Build the heap testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module heapTb \
  -f verilog.f -o heapSim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/heapSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -eq 0 ] && grep -q "All tests passed!" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: sim/heapTb.sv
/*
  Heap testbench
  APB driver, reference model of the heap and checks of every result
*/
`timescale 1ns/10ps
`include "heap_macros.svh"

module heapTb;
  import heapStorePkg::*;
  import heapOpPkg::*;

  logic                       clock = 1'b0;
  logic                       resetN, pSel, pEnable, pWrite, pReady, pSlvErr;
  logic [`HEAP_ADDR_BITS-1:0] pAddr;
  data_t                      pWData, pRData;

  data_t mData [`HEAP_ARRAYS][`HEAP_LENGTH];   // Model contents
  int    mSize [`HEAP_ARRAYS];
  bit    mAlloc [`HEAP_ARRAYS];
  int    freeIds [$];                          // Freed ids reused last in first out
  int    freshNext;
  data_t got;

  heapTop u_dut (.*);

  always #5 clock = ~clock;                    // 10 ns period

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  // --------------------
  // APB master
  task automatic apbTransfer(input logic write, input logic [`HEAP_ADDR_BITS-1:0] addr,
                             input data_t wData, output data_t rData, output logic slvErr);
    int waited;
    @(posedge clock);
    #1;
    pSel   = 1'b1;                             // Setup phase
    pWrite = write;
    pAddr  = addr;
    pWData = wData;
    @(posedge clock);
    #1;
    pEnable = 1'b1;                            // Access phase
    waited  = 0;
    @(negedge clock);
    while (!pReady && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (!pReady)
      failRun("APB transfer never got pReady within 20 cycles");
    rData  = pRData;
    slvErr = pSlvErr;
    @(posedge clock);
    #1;
    pSel    = 1'b0;
    pEnable = 1'b0;
  endtask

  task automatic apbWrite(input logic [`HEAP_ADDR_BITS-1:0] addr, input data_t wData,
                          output logic slvErr);
    data_t ignored;
    apbTransfer(1'b1, addr, wData, ignored, slvErr);
  endtask

  task automatic apbRead(output data_t rData, output logic slvErr);
    apbTransfer(1'b0, '0, '0, rData, slvErr);
  endtask

  // --------------------
  // Reference model giving the value a later read transfer returns
  task automatic modelOp(input logic [4:0] op, input int arr, input int idx,
                         input data_t operand, output errKind_t err, output data_t result);
    data_t prev;
    err    = errNone;
    result = '0;
    prev   = mData[arr][idx];
    if (!(op inside {opClear, opWrite, opRead, opSize, opPush, opPop, opAlloc, opFree,
                     opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd})) begin
      err = errBadOp;
    end else if (op == opClear) begin
      foreach (mAlloc[i]) mAlloc[i] = 1'b0;
      freeIds.delete();
      freshNext = 0;
    end else if (op == opAlloc) begin
      if (freeIds.size() > 0) begin
        result = data_t'(freeIds.pop_back());  // Most recent free
      end else if (freshNext < `HEAP_ARRAYS) begin
        result = data_t'(freshNext);
        freshNext++;
      end else begin
        err = errOutOfMemory;
      end
      if (err == errNone) begin
        mAlloc[result] = 1'b1;
        mSize[result]  = 0;
      end
    end else if (!mAlloc[arr]) begin
      err = errNotAllocated;
    end else begin
      case (op)
        opWrite: begin
          mData[arr][idx] = operand;
          if (idx >= mSize[arr]) mSize[arr] = idx + 1;   // Grows the array
        end
        opRead: begin
          if (idx >= mSize[arr])
            err = errOutOfBounds;
          else
            result = prev;
        end
        opSize: result = data_t'(mSize[arr]);
        opPush: begin
          if (mSize[arr] == `HEAP_LENGTH) begin
            err = errFull;
          end else begin
            mData[arr][mSize[arr]] = operand;
            mSize[arr]++;
          end
        end
        opPop: begin
          if (mSize[arr] == 0) begin
            err = errEmpty;
          end else begin
            mSize[arr]--;
            result = mData[arr][mSize[arr]];
          end
        end
        opFree: begin
          mAlloc[arr] = 1'b0;
          freeIds.push_back(arr);
        end
        default: begin                         // Read-modify-write group
          if (idx >= mSize[arr]) begin
            err = errOutOfBounds;
          end else begin
            case (op)
              opAdd, opAddAfter: mData[arr][idx] = prev + operand;   // 16-bit wrap
              opSub, opSubAfter: mData[arr][idx] = prev - operand;
              opOr:              mData[arr][idx] = prev | operand;
              opXor:             mData[arr][idx] = prev ^ operand;
              default:           mData[arr][idx] = prev & operand;
            endcase
            result = (op == opAddAfter || op == opSubAfter) ? prev : mData[arr][idx];
          end
        end
      endcase
    end
    if (err != errNone) result = data_t'(err);  // Error code in the result register
  endtask

  // One operation as a write transfer followed by a read of the result
  task automatic doOp(input logic [4:0] op, input int arr, input int idx,
                      input data_t operand, output data_t rData);
    errKind_t expErr;
    data_t    expData;
    logic     slvErr;
    modelOp(op, arr, idx, operand, expErr, expData);
    apbWrite({op, arrayId_t'(arr), index_t'(idx)}, operand, slvErr);
    assert (slvErr == (expErr != errNone))
      else failRun($sformatf("ERROR at %0t ns: pSlvErr %b on opcode %0d", $time, slvErr, op));
    apbRead(rData, slvErr);
    assert (!slvErr && rData == expData)
      else failRun($sformatf("ERROR at %0t ns: op %0d array %0d index %0d gave %h, expected %h",
                             $time, op, arr, idx, rData, expData));
  endtask

  task automatic checkUnchanged(input int arr, input int idx);
    data_t rData;
    doOp(opSize, arr, 0, '0, rData);
    doOp(opRead, arr, idx, '0, rData);
  endtask

  initial begin
    logic [4:0] allOps [13];
    int         idx;
    allOps  = '{opWrite, opRead, opSize, opPush, opPop, opFree, opAdd, opAddAfter,
                opSub, opSubAfter, opOr, opXor, opAnd};   // Last seven are RMW
    resetN  = 1'b0;
    pSel    = 1'b0;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    pAddr   = '0;
    pWData  = '0;
    void'($urandom(32'h26bf_a3ee));
    repeat (8) @(posedge clock);
    #1;
    resetN = 1'b1;

    // Allocation, out of memory and LIFO reuse
    doOp(opClear, 0, 0, '0, got);
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      doOp(opAlloc, 0, 0, '0, got);
      assert (got == data_t'(i))
        else failRun($sformatf("ERROR at %0t ns: alloc gave id %0d, expected %0d", $time, got, i));
    end
    doOp(opAlloc, 0, 0, '0, got);              // No id left
    checkUnchanged(0, 0);
    doOp(opFree, 5, 0, '0, got);
    doOp(opFree, 2, 0, '0, got);
    doOp(opAlloc, 0, 0, '0, got);              // 2 comes back first
    doOp(opAlloc, 0, 0, '0, got);
    doOp(opFree, 6, 0, '0, got);
    doOp(opFree, 6, 0, '0, got);               // Double free

    // Write, read and size on array 5
    doOp(opWrite, 5, 3, data_t'($urandom), got);
    doOp(opSize, 5, 0, '0, got);
    for (int i = 0; i < 3; i++) doOp(opWrite, 5, i, data_t'($urandom), got);
    for (int i = 0; i < 5; i++) doOp(opRead, 5, i, '0, got);   // Index 4 out of bounds
    checkUnchanged(5, 3);
    foreach (allOps[i]) doOp(allOps[i], 6, 1, data_t'($urandom), got);   // Freed array

    // Push to full, pop to empty on array 2
    for (int i = 0; i < 9; i++) doOp(opPush, 2, 0, data_t'($urandom), got);
    checkUnchanged(2, 7);
    for (int i = 0; i < 9; i++) doOp(opPop, 2, 0, '0, got);
    checkUnchanged(2, 0);

    // Read-modify-write with wrap at 16 bits
    doOp(opWrite, 5, 1, 16'hfff0, got);
    doOp(opAdd, 5, 1, 16'h0025, got);
    doOp(opSubAfter, 5, 1, 16'h0040, got);
    doOp(opRead, 5, 1, '0, got);
    for (int i = 0; i < 28; i++) begin
      idx = $urandom % 4;
      doOp(allOps[6 + i % 7], 5, idx, data_t'($urandom), got);
      doOp(opRead, 5, idx, '0, got);
    end

    // Unknown opcodes leave no trace
    doOp(5'd0, 5, 2, data_t'($urandom), got);
    doOp(5'd9, 5, 2, data_t'($urandom), got);
    doOp(5'd31, 5, 2, data_t'($urandom), got);
    checkUnchanged(5, 2);

    // Clear drops every array
    doOp(opClear, 0, 0, '0, got);
    for (int i = 0; i < `HEAP_ARRAYS; i++) doOp(opSize, i, 0, '0, got);
    doOp(opAlloc, 0, 0, '0, got);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: sim/heap_sva.sv
/*
  Heap APB timing checks
  Bound to heapTop to check ready placement, error strobe and reset values
*/
`timescale 1ns/10ps

module heapSva (
  input logic clock,
  input logic resetN,
  input logic pSel,
  input logic pEnable,
  input logic pWrite,
  input logic pReady,
  input logic pSlvErr
);

  logic [1:0] waitCycles;                      // Access cycles spent without pReady

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      waitCycles <= '0;
    else if (pSel && pEnable && !pReady)
      waitCycles <= waitCycles + 1'b1;         // Still waiting in access
    else
      waitCycles <= '0;
  end

  // --------------------
  // Transfer timing
  writeInThirdCycle: assert property (@(posedge clock) disable iff (!resetN)
    pSel && pEnable && pWrite |-> (pReady == (waitCycles == 2'd2)))
    else $error("APB write pReady outside the third access cycle");

  readInFirstCycle: assert property (@(posedge clock) disable iff (!resetN)
    pSel && pEnable && !pWrite |-> pReady)
    else $error("APB read not ready in its first access cycle");

  // Errors only close a write transfer
  errorOnlyWithReady: assert property (@(posedge clock) disable iff (!resetN)
    pSlvErr |-> pReady && pSel && pEnable && pWrite)
    else $error("pSlvErr high outside a completing write transfer");

  quietInReset: assert property (@(posedge clock) !resetN |-> !pReady && !pSlvErr)
    else $error("pReady or pSlvErr high during reset");

endmodule

bind heapTop heapSva u_sva (
  .clock   (clock),
  .resetN  (resetN),
  .pSel    (pSel),
  .pEnable (pEnable),
  .pWrite  (pWrite),
  .pReady  (pReady),
  .pSlvErr (pSlvErr)
);

// File: src/arrayAllocator.sv
/*
  Array allocator
  Allocation bits, a LIFO of freed ids and a fresh-id counter
*/
`timescale 1ns/10ps
`include "heap_macros.svh"

module arrayAllocator (
  input logic        clock,
  input logic        resetN,
  allocIf.allocator  alloc
);
  import heapStorePkg::*;

  logic [`HEAP_ARRAYS-1:0]   allocated;        // One bit per array
  arrayId_t                  freeStack [`HEAP_ARRAYS];
  logic [`HEAP_ARRAY_BITS:0] freeTop;          // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0] freshCount;       // Ids handed out fresh
  arrayId_t                  topIndex;

  assign topIndex          = freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign alloc.isAllocated = allocated[alloc.arrayId];
  assign alloc.grantId     = (freeTop != '0) ? freeStack[topIndex]
                                             : freshCount[`HEAP_ARRAY_BITS-1:0];
  assign alloc.outOfMemory = (freeTop == '0) && (freshCount == `HEAP_ARRAYS);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      freeTop    <= '0;
      freshCount <= '0;
    end else if (alloc.clearReq) begin       // Whole heap empty
      allocated  <= '0;
      freeTop    <= '0;
      freshCount <= '0;
    end else if (alloc.allocReq) begin
      if (freeTop != '0)
        freeTop <= freeTop - 1'b1;             // Reuse last freed
      else
        freshCount <= freshCount + 1'b1;
      allocated[alloc.grantId] <= 1'b1;
    end else if (alloc.freeReq) begin
      freeTop                  <= freeTop + 1'b1;
      allocated[alloc.arrayId] <= 1'b0;        // The freed id itself
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.freeReq)
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= alloc.arrayId;
  end

endmodule

// File: src/elementStore.sv
/*
  Element store
  64-entry element memory with registered read and
  read-modify-write ALU
*/
`timescale 1ns/10ps
`include "heap_macros.svh"

module elementStore (
  input logic    clock,
  storeIf.store  store
);
  import heapStorePkg::*;
  import heapOpPkg::*;

  data_t memory [`HEAP_ARRAYS * `HEAP_LENGTH];  // Fixed block per array
  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] address;

  assign address = {store.arrayId, store.index};

  // ------------------
  // ALU on the registered element
  always_comb begin
    case (store.aluOp)
      aluAdd:  store.newData = store.oldData + store.operand;   // Wraps at 16 bits
      aluSub:  store.newData = store.oldData - store.operand;
      aluOr:   store.newData = store.oldData | store.operand;
      aluXor:  store.newData = store.oldData ^ store.operand;
      aluAnd:  store.newData = store.oldData & store.operand;
      default: store.newData = store.operand;                   // Plain write
    endcase
  end

  always_ff @(posedge clock) begin
    store.oldData <= memory[address];          // One cycle read latency
    if (store.writeEn)
      memory[address] <= store.newData;
  end

endmodule

// File: src/heapControl.sv
/*
  Heap control
  APB slave that sequences one operation per write transfer,
  runs the checks and keeps the result register
*/
`timescale 1ns/10ps
`include "heap_macros.svh"

module heapControl (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       pSel,
  input  logic                       pEnable,
  input  logic                       pWrite,
  input  logic [`HEAP_ADDR_BITS-1:0] pAddr,
  input  heapStorePkg::data_t        pWData,
  output logic                       pReady,
  output logic                       pSlvErr,
  output heapStorePkg::data_t        pRData,
  allocIf.control                    alloc,
  sizeIf.control                     sizes,
  storeIf.control                    store
);
  import heapStorePkg::*;
  import heapOpPkg::*;

  ctrlState_t state;
  opcode_t    opReg, curOp;                    // Latched and current opcode
  arrayId_t   arrayReg, curArray;
  index_t     indexReg, curIndex;
  data_t      operandReg;
  errKind_t   errReg, errNext;
  errKind_t   errWrite, errRead;               // Writable and readable checks
  data_t      resultReg, resultValue;
  logic       setupWrite, execute;
  logic       notAllocated, outOfBounds;
  logic       storeWrite, sizeWrite;
  size_t      sizeNext;
  index_t     storeIndex;
  aluOp_t     aluSel;

  assign setupWrite = pSel && !pEnable && pWrite;
  assign execute    = (state == stExecute) && (errReg == errNone);   // Writes only when clean

  // During setup the fields come straight off the bus so the read starts early
  assign curOp    = (state == stIdle) ? opcode_t'(pAddr[`HEAP_OP_MSB:`HEAP_OP_LSB]) : opReg;
  assign curArray = (state == stIdle) ? pAddr[`HEAP_ARRAY_MSB:`HEAP_ARRAY_LSB] : arrayReg;
  assign curIndex = (state == stIdle) ? pAddr[`HEAP_INDEX_MSB:`HEAP_INDEX_LSB] : indexReg;

  assign notAllocated = !alloc.isAllocated;
  assign outOfBounds  = size_t'(curIndex) >= sizes.size;
  assign errWrite     = notAllocated ? errNotAllocated : errNone;
  assign errRead      = notAllocated ? errNotAllocated : (outOfBounds ? errOutOfBounds : errNone);

  // ------------------
  // Opcode decode
  always_comb begin
    errNext     = errNone;
    aluSel      = aluPass;
    storeWrite  = 1'b0;
    sizeWrite   = 1'b0;
    sizeNext    = sizes.size;
    storeIndex  = curIndex;
    resultValue = '0;                          // Zero for write, push, clear, free
    case (curOp)
      opClear: errNext = errNone;
      opWrite: begin
        errNext    = errWrite;
        storeWrite = 1'b1;
        sizeWrite  = outOfBounds;              // Grow to index plus one
        sizeNext   = size_t'(curIndex) + 1'b1;
      end
      opRead: begin
        errNext     = errRead;
        resultValue = store.oldData;
      end
      opSize: begin
        errNext     = errWrite;
        resultValue = data_t'(sizes.size);
      end
      opPush: begin
        errNext    = notAllocated ? errNotAllocated :
                     ((sizes.size == `HEAP_LENGTH) ? errFull : errNone);
        storeIndex = sizes.size[`HEAP_INDEX_BITS-1:0];   // Slot past the end
        storeWrite = 1'b1;
        sizeWrite  = 1'b1;
        sizeNext   = sizes.size + 1'b1;
      end
      opPop: begin
        errNext     = notAllocated ? errNotAllocated :
                      ((sizes.size == '0) ? errEmpty : errNone);
        sizeNext    = sizes.size - 1'b1;
        storeIndex  = sizeNext[`HEAP_INDEX_BITS-1:0];    // Last element
        sizeWrite   = 1'b1;
        resultValue = store.oldData;
      end
      opAlloc: begin
        errNext     = alloc.outOfMemory ? errOutOfMemory : errNone;
        sizeWrite   = 1'b1;                    // New array starts empty
        sizeNext    = '0;
        resultValue = data_t'(alloc.grantId);
      end
      opFree: errNext = errWrite;
      opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd: begin
        errNext    = errRead;
        storeWrite = 1'b1;
        case (curOp)
          opAdd, opAddAfter: aluSel = aluAdd;
          opSub, opSubAfter: aluSel = aluSub;
          opOr:              aluSel = aluOr;
          opXor:             aluSel = aluXor;
          default:           aluSel = aluAnd;
        endcase
        resultValue = (curOp == opAddAfter || curOp == opSubAfter) ? store.oldData
                                                                   : store.newData;
      end
      default: errNext = errBadOp;
    endcase
  end

  // ------------------
  // Datapath requests
  assign alloc.arrayId  = curArray;
  assign alloc.allocReq = execute && (curOp == opAlloc);
  assign alloc.freeReq  = execute && (curOp == opFree);
  assign alloc.clearReq = execute && (curOp == opClear);

  assign sizes.arrayId = (curOp == opAlloc) ? alloc.grantId : curArray;   // Alloc sizes the grant
  assign sizes.setSize = execute && sizeWrite;
  assign sizes.newSize = sizeNext;

  assign store.arrayId = curArray;
  assign store.index   = storeIndex;
  assign store.operand = operandReg;
  assign store.aluOp   = aluSel;
  assign store.writeEn = execute && storeWrite;

  // ------------------
  // Sequencer
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= stIdle;
      errReg    <= errNone;
      resultReg <= '0;
    end else begin
      case (state)
        stIdle: if (setupWrite) state <= stCheck;
        stCheck: begin
          errReg <= errNext;                   // Checks settle here
          state  <= stExecute;
        end
        stExecute: begin
          resultReg <= (errReg == errNone) ? resultValue : data_t'(errReg);
          state     <= stDone;
        end
        default: state <= stIdle;              // stDone completes the transfer
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle && setupWrite) begin   // Setup phase latch
      opReg      <= curOp;
      arrayReg   <= curArray;
      indexReg   <= curIndex;
      operandReg <= pWData;
    end
  end

  // Reads complete at once, writes in the third access cycle
  assign pReady  = (state == stDone) || (state == stIdle && pSel && pEnable && !pWrite);
  assign pSlvErr = (state == stDone) && (errReg != errNone);
  assign pRData  = resultReg;

endmodule

// File: src/heapIf.sv
/*
  Internal heap buses
  Control to allocator, size table and element store
*/
`timescale 1ns/10ps

interface allocIf;
  import heapStorePkg::*;

  logic     allocReq;                          // Single cycle pulses
  logic     freeReq;
  logic     clearReq;
  arrayId_t arrayId;                           // Array being checked or freed
  logic     isAllocated;
  arrayId_t grantId;                           // Id the next alloc gets
  logic     outOfMemory;

  modport control (output allocReq, freeReq, clearReq, arrayId,
                   input isAllocated, grantId, outOfMemory);
  modport allocator (input allocReq, freeReq, clearReq, arrayId,
                     output isAllocated, grantId, outOfMemory);
endinterface

interface sizeIf;
  import heapStorePkg::*;

  arrayId_t arrayId;
  logic     setSize;                           // Write strobe
  size_t    newSize;
  size_t    size;                              // Combinational lookup

  modport control (output arrayId, setSize, newSize, input size);
  modport lookup (input arrayId, setSize, newSize, output size);
endinterface

interface storeIf;
  import heapStorePkg::*;
  import heapOpPkg::*;

  arrayId_t arrayId;
  index_t   index;
  data_t    operand;
  aluOp_t   aluOp;
  logic     writeEn;
  data_t    oldData;                           // Registered read
  data_t    newData;                           // ALU result on oldData

  modport control (output arrayId, index, operand, aluOp, writeEn, input oldData, newData);
  modport store (input arrayId, index, operand, aluOp, writeEn, output oldData, newData);
endinterface

// File: src/heapOpPkg.sv
/*
  Heap operation types
  Opcodes, ALU functions, error kinds and control FSM states
*/
`include "heap_macros.svh"

package heapOpPkg;

  typedef enum logic [`HEAP_OP_MSB-`HEAP_OP_LSB:0] {
    opClear    = 5'd1,                         // Drop every array
    opWrite    = 5'd2,
    opRead     = 5'd3,
    opSize     = 5'd4,
    opPush     = 5'd14,
    opPop      = 5'd15,
    opAlloc    = 5'd18,
    opFree     = 5'd19,
    opAdd      = 5'd20,                        // Returns new value
    opAddAfter = 5'd21,                        // Returns previous value
    opSub      = 5'd22,
    opSubAfter = 5'd23,
    opOr       = 5'd28,
    opXor      = 5'd29,
    opAnd      = 5'd30
  } opcode_t;

  typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluOr, aluXor, aluAnd} aluOp_t;

  typedef enum logic [2:0] {
    errNone = 3'd0, errNotAllocated = 3'd1, errOutOfBounds = 3'd2, errFull = 3'd3,
    errEmpty = 3'd4, errOutOfMemory = 3'd5, errBadOp = 3'd6
  } errKind_t;

  typedef enum logic [1:0] {stIdle, stCheck, stExecute, stDone} ctrlState_t;

endpackage

// File: src/heapStorePkg.sv
/*
  Heap storage types
  Array ids, element positions, sizes and element values
*/
`include "heap_macros.svh"

package heapStorePkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId_t;   // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] index_t;     // Element position

  // One extra bit so a full array reads as 8
  typedef logic [`HEAP_INDEX_BITS:0]   size_t;

  typedef logic [`HEAP_DATA_BITS-1:0]  data_t;      // Element value

endpackage

// File: src/heapTop.sv
/*
  Heap top level
  APB slave ports onto control, allocator, size table and store
*/
`timescale 1ns/10ps
`include "heap_macros.svh"

module heapTop (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       pSel,
  input  logic                       pEnable,
  input  logic                       pWrite,
  input  logic [`HEAP_ADDR_BITS-1:0] pAddr,
  input  heapStorePkg::data_t        pWData,
  output logic                       pReady,
  output logic                       pSlvErr,
  output heapStorePkg::data_t        pRData
);

  allocIf allocBus ();                         // Control to allocator
  sizeIf  sizeBus ();                          // Control to size table
  storeIf storeBus ();                         // Control to element store

  heapControl u_control (
    .clock   (clock),
    .resetN  (resetN),
    .pSel    (pSel),
    .pEnable (pEnable),
    .pWrite  (pWrite),
    .pAddr   (pAddr),
    .pWData  (pWData),
    .pReady  (pReady),
    .pSlvErr (pSlvErr),
    .pRData  (pRData),
    .alloc   (allocBus),
    .sizes   (sizeBus),
    .store   (storeBus)
  );

  arrayAllocator u_allocator (.clock(clock), .resetN(resetN), .alloc(allocBus));

  sizeTable u_sizeTable (.clock(clock), .resetN(resetN), .sizes(sizeBus));

  elementStore u_elementStore (.clock(clock), .store(storeBus));

endmodule

// File: src/heap_macros.svh
/*
  Heap sizing macros
  Array, index and element widths plus the APB address field layout
*/
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

`define HEAP_ARRAY_BITS 3                      // Bits in an array id
`define HEAP_INDEX_BITS 3                      // Bits in an element index
`define HEAP_DATA_BITS  16                     // Element width

`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)    // Number of arrays
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)    // Elements per array

// ------------------
`define HEAP_ADDR_BITS 11                      // APB address width
`define HEAP_INDEX_LSB 0                       // Index field
`define HEAP_INDEX_MSB 2
`define HEAP_ARRAY_LSB 3                       // Array field
`define HEAP_ARRAY_MSB 5
`define HEAP_OP_LSB    6                       // Opcode field
`define HEAP_OP_MSB    10

`endif

// File: src/sizeTable.sv
/*
  Size table
  Current element count of every array
*/
`timescale 1ns/10ps
`include "heap_macros.svh"

module sizeTable (
  input logic    clock,
  input logic    resetN,
  sizeIf.lookup  sizes
);
  import heapStorePkg::*;

  size_t sizeMem [`HEAP_ARRAYS];               // 0 to 8 per array

  assign sizes.size = sizeMem[sizes.arrayId];  // Same cycle answer

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizeMem[i] <= '0;
      end
    end else if (sizes.setSize) begin
      sizeMem[sizes.arrayId] <= sizes.newSize;
    end
  end

endmodule

// File: verilog.f
+incdir+src
src/heapStorePkg.sv
src/heapOpPkg.sv
src/heapIf.sv
src/heapControl.sv
src/arrayAllocator.sv
src/sizeTable.sv
src/elementStore.sv
src/heapTop.sv
sim/heap_sva.sv
sim/heapTb.sv
